//--- id_stage.f
src/rv_id_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/rf_apb_port.sv
src/id_ex_reg.sv
src/id_stage.sv
sim/tb_id_stage.sv

//--- sim/id_vectors.txt
# I inst pc stall flush | kind imm rd rd_we illegal rs1_data rs2_data   (all hex)
# W addr data (lands with the next I line) | A write addr data pslverr
W 01 0000abcd
I 002081b3 00000010 0 0 08 00000000 03 1 0 00000000 00000000
I 002081b3 00000011 0 0 08 00000000 03 1 0 0000abcd 00000000
W 02 ffff0001
I 123452b7 00000012 0 0 01 12345000 05 1 0 00000000 00000000
I 40208233 00000013 0 0 08 00000000 04 1 0 0000abcd ffff0001
W 00 deadbeef
I fff08313 00000014 0 0 09 ffffffff 06 1 0 0000abcd 00000000
I 40315393 00000015 0 0 0a 00000003 07 1 0 ffff0001 00000000
I ffc0a403 00000016 0 0 03 fffffffc 08 1 0 0000abcd 00000000
I 0020a423 00000017 0 0 04 00000008 00 0 0 0000abcd ffff0001
I fe208ce3 00000018 0 0 07 fffffff8 00 0 0 0000abcd ffff0001
I 001000ef 00000019 0 0 05 00000800 01 1 0 00000000 0000abcd
I 00008067 0000001a 0 0 06 00000000 00 1 0 0000abcd 00000000
I fffff497 0000001b 0 0 02 fffff000 09 1 0 00000000 00000000
I 0ff0000f 0000001c 0 0 0b 00000000 00 0 0 00000000 00000000
I 0000100f 0000001d 0 0 0c 00000000 00 0 0 00000000 00000000
I 30009573 0000001e 0 0 0d 00000300 0a 1 0 0000abcd 00000000
I 00000073 0000001f 0 0 0e 00000000 00 0 0 00000000 00000000
I 00100073 00000020 0 0 0f 00000000 00 0 0 00000000 0000abcd
I 30200073 00000021 0 0 10 00000000 00 0 0 00000000 ffff0001
I 10500073 00000022 0 0 11 00000000 00 0 0 00000000 00000000
I 00200073 00000023 0 0 00 00000000 00 0 1 00000000 ffff0001
I 002081b2 00000024 0 0 00 00000000 00 0 1 0000abcd ffff0001
I 022081b3 00000025 0 0 00 00000000 00 0 1 0000abcd ffff0001
I 04109093 00000026 0 0 00 00000000 00 0 1 0000abcd 0000abcd
I ffffffff 00000027 0 0 00 00000000 00 0 1 00000000 00000000
I 000001b3 00000028 0 0 08 00000000 03 1 0 00000000 00000000
I 002081b3 00000030 0 0 08 00000000 03 1 0 0000abcd ffff0001
I 40208233 00000031 1 0 08 00000000 04 1 0 0000abcd ffff0001
I 123452b7 00000032 1 0 01 12345000 05 1 0 00000000 00000000
I fff08313 00000033 1 1 09 ffffffff 06 1 0 0000abcd 00000000
I fff08313 00000034 0 0 09 ffffffff 06 1 0 0000abcd 00000000
A 0 04 0000abcd 0
A 0 08 ffff0001 0
A 1 0c 13572468 0
A 0 0c 13572468 0
A 1 00 ffffffff 0
A 0 00 00000000 0
A 0 80 00000000 1
A 1 fc 00000000 1
I 00318233 00000035 0 0 08 00000000 04 1 0 13572468 13572468

//--- sim/tb_id_stage.sv
module tb_id_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam string vec_file        = "sim/id_vectors.txt";
    localparam int    clk_period      = 40;
    localparam int    cycles_per_line = 40;

    logic                       clk;
    logic                       rst_n;
    logic [rv_id_pkg::xlen-1:0] inst;
    logic [29:0]                pc;
    logic                       stall;
    logic                       flush;
    rv_id_pkg::wb_t             wb;
    rv_id_pkg::fwd_t            fwd;
    rv_id_pkg::id_ex_t          ex;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [7:0]                 paddr;
    logic [rv_id_pkg::xlen-1:0] pwdata;
    logic [rv_id_pkg::xlen-1:0] prdata;
    logic                       pready;
    logic                       pslverr;

    rv_id_pkg::id_ex_t          exp_ex;
    rv_id_pkg::wb_t             pending_wb;
    string                      lines[$];
    int                         n_lines;
    bit                         loaded;
    int                         mismatches;
    int                         failures;
    int                         checks;
    integer                     seed;

    id_stage #(
        .apb_addr_width (8)
    ) u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst    (inst),
        .pc      (pc),
        .stall   (stall),
        .flush   (flush),
        .wb      (wb),
        .fwd     (fwd),
        .ex      (ex),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic reads_rs1(input rv_id_pkg::op_kind_e kind);
        return kind inside {rv_id_pkg::load, rv_id_pkg::store, rv_id_pkg::jalr,
                            rv_id_pkg::branch, rv_id_pkg::alu, rv_id_pkg::alui,
                            rv_id_pkg::alui_shamt, rv_id_pkg::csr};
    endfunction

    function automatic logic reads_rs2(input rv_id_pkg::op_kind_e kind);
        return kind inside {rv_id_pkg::store, rv_id_pkg::branch, rv_id_pkg::alu};
    endfunction

    // kinds whose funct3 selects an operation, a condition or a width
    function automatic logic uses_funct3(input rv_id_pkg::op_kind_e kind);
        return kind inside {rv_id_pkg::load, rv_id_pkg::store, rv_id_pkg::jalr,
                            rv_id_pkg::branch, rv_id_pkg::alu, rv_id_pkg::alui,
                            rv_id_pkg::alui_shamt, rv_id_pkg::csr};
    endfunction

    task automatic flag_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("ERR %0t ns %s exp %h act %h", $time, sig, exp_v, act_v);
        mismatches++;
    endtask

    task automatic check_word(input string sig, input logic [rv_id_pkg::xlen-1:0] exp_v,
                              input logic [rv_id_pkg::xlen-1:0] act_v);
        checks++;
        if (act_v !== exp_v) flag_mismatch(sig, exp_v, act_v);
    endtask

    task automatic check_fwd(input rv_id_pkg::fwd_t exp_v, input rv_id_pkg::fwd_t act_v);
        checks++;
        if (act_v.rs1 !== exp_v.rs1) flag_mismatch("fwd.rs1", exp_v.rs1, act_v.rs1);
        if (act_v.rs2 !== exp_v.rs2) flag_mismatch("fwd.rs2", exp_v.rs2, act_v.rs2);
        if (act_v.rs1_used !== exp_v.rs1_used)
            flag_mismatch("fwd.rs1_used", exp_v.rs1_used, act_v.rs1_used);
        if (act_v.rs2_used !== exp_v.rs2_used)
            flag_mismatch("fwd.rs2_used", exp_v.rs2_used, act_v.rs2_used);
    endtask

    task automatic check_ex(input rv_id_pkg::id_ex_t exp_v, input rv_id_pkg::id_ex_t act_v);
        checks++;
        if (act_v.valid !== exp_v.valid) flag_mismatch("ex.valid", exp_v.valid, act_v.valid);
        if (act_v.dec.kind !== exp_v.dec.kind)
            flag_mismatch("ex.dec.kind", exp_v.dec.kind, act_v.dec.kind);
        if (act_v.dec.rd_we !== exp_v.dec.rd_we)
            flag_mismatch("ex.dec.rd_we", exp_v.dec.rd_we, act_v.dec.rd_we);
        // payload of an empty slot is don't care
        if (exp_v.valid) begin
            if (act_v.pc !== exp_v.pc) flag_mismatch("ex.pc", exp_v.pc, act_v.pc);
            if (uses_funct3(exp_v.dec.kind) && act_v.dec.funct3 !== exp_v.dec.funct3)
                flag_mismatch("ex.dec.funct3", exp_v.dec.funct3, act_v.dec.funct3);
            if (exp_v.dec.kind inside {rv_id_pkg::alu, rv_id_pkg::alui_shamt}
                && act_v.dec.alt !== exp_v.dec.alt)
                flag_mismatch("ex.dec.alt", exp_v.dec.alt, act_v.dec.alt);
            if (act_v.dec.imm !== exp_v.dec.imm)
                flag_mismatch("ex.dec.imm", exp_v.dec.imm, act_v.dec.imm);
            if (act_v.dec.rd !== exp_v.dec.rd)
                flag_mismatch("ex.dec.rd", exp_v.dec.rd, act_v.dec.rd);
            if (act_v.dec.illegal !== exp_v.dec.illegal)
                flag_mismatch("ex.dec.illegal", exp_v.dec.illegal, act_v.dec.illegal);
            if (act_v.dec.rs1_used !== exp_v.dec.rs1_used)
                flag_mismatch("ex.dec.rs1_used", exp_v.dec.rs1_used, act_v.dec.rs1_used);
            if (act_v.dec.rs2_used !== exp_v.dec.rs2_used)
                flag_mismatch("ex.dec.rs2_used", exp_v.dec.rs2_used, act_v.dec.rs2_used);
            if (act_v.rs1_data !== exp_v.rs1_data)
                flag_mismatch("ex.rs1_data", exp_v.rs1_data, act_v.rs1_data);
            if (act_v.rs2_data !== exp_v.rs2_data)
                flag_mismatch("ex.rs2_data", exp_v.rs2_data, act_v.rs2_data);
        end
    endtask

    task automatic run_inst(input string line);
        logic [31:0]         v_inst, v_pc, v_stall, v_flush;
        logic [31:0]         v_kind, v_imm, v_rd, v_rd_we;
        logic [31:0]         v_ill, v_rs1, v_rs2;
        rv_id_pkg::op_kind_e kind;
        rv_id_pkg::fwd_t     exp_fwd;
        int                  n;
        n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h", v_inst, v_pc, v_stall,
                    v_flush, v_kind, v_imm, v_rd, v_rd_we, v_ill, v_rs1, v_rs2);
        if (n != 11) begin
            $display("instruction line has %0d fields instead of 11: %s", n, line);
            failures++;
            return;
        end
        kind = rv_id_pkg::op_kind_e'(v_kind[4:0]);
        @(posedge clk);
        inst  <= v_inst;
        pc    <= v_pc[29:0];
        stall <= v_stall[0];
        flush <= v_flush[0];
        wb    <= pending_wb;
        pending_wb = '0;
        // rs1 and rs2 sit at the same bits in every format
        exp_fwd = '{rs1: v_inst[19:15], rs2: v_inst[24:20],
                    rs1_used: reads_rs1(kind), rs2_used: reads_rs2(kind)};
        @(negedge clk);
        check_fwd(exp_fwd, fwd);
        if (v_flush[0]) begin
            exp_ex.valid     = 1'b0;
            exp_ex.dec.kind  = rv_id_pkg::none;
            exp_ex.dec.rd_we = 1'b0;
        end else if (!v_stall[0]) begin
            exp_ex.valid        = 1'b1;
            exp_ex.pc           = v_pc[29:0];
            exp_ex.dec.kind     = kind;
            exp_ex.dec.funct3   = v_inst[14:12];
            exp_ex.dec.alt      = v_inst[30];
            exp_ex.dec.imm      = v_imm;
            exp_ex.dec.rd       = v_rd[4:0];
            exp_ex.dec.rd_we    = v_rd_we[0];
            exp_ex.dec.illegal  = v_ill[0];
            exp_ex.dec.rs1_used = reads_rs1(kind);
            exp_ex.dec.rs2_used = reads_rs2(kind);
            exp_ex.rs1_data     = v_rs1;
            exp_ex.rs2_data     = v_rs2;
        end
        // park the pipe so ex holds between lines
        @(posedge clk);
        stall <= 1'b1;
        flush <= 1'b0;
        wb    <= '0;
        @(negedge clk);
        check_ex(exp_ex, ex);
    endtask

    task automatic load_wb(input string line);
        logic [31:0] v_addr;
        logic [31:0] v_data;
        if ($sscanf(line, "W %h %h", v_addr, v_data) != 2) begin
            $display("write-back line is malformed: %s", line);
            failures++;
        end else begin
            pending_wb = '{we: 1'b1, addr: v_addr[4:0], data: v_data};
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                            input logic [31:0] data, input logic exp_err);
        int             hold;
        int             waited;
        logic           done;
        rv_id_pkg::wb_t busy_wb;
        hold   = wr ? 1 + ($unsigned($random(seed)) % 3) : 0;
        waited = 0;
        done   = 1'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        while (!done && waited < 16) begin
            // write-back to x0 keeps the port busy without changing state
            busy_wb = '0;
            if (waited < hold) begin
                busy_wb.we   = 1'b1;
                busy_wb.data = $random(seed);
            end
            @(posedge clk);
            penable <= 1'b1;
            wb      <= busy_wb;
            @(negedge clk);
            if (pready) begin
                done = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!done) begin
            $display("APB transfer at address %h never raised pready", addr);
            failures++;
        end else begin
            check_word("pslverr", exp_err, pslverr);
            if (!wr && !exp_err) check_word("prdata", data, prdata);
            check_word("apb wait cycles", (wr && !exp_err) ? hold : 0, waited);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        wb      <= '0;
    endtask

    task automatic run_apb(input string line);
        logic [31:0] v_wr, v_addr, v_data, v_err;
        if ($sscanf(line, "A %h %h %h %h", v_wr, v_addr, v_data, v_err) != 4) begin
            $display("APB line is malformed: %s", line);
            failures++;
        end else begin
            apb_xfer(v_wr[0], v_addr[7:0], v_data, v_err[0]);
        end
    endtask

    initial begin
        wait (loaded);
        #(n_lines * cycles_per_line * clk_period);
        $display("watchdog expired, %0d vector lines did not finish in time", n_lines);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        integer fd;
        string  line;
        int     gap;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst       = '0;
        pc         = '0;
        stall      = 1'b1;
        flush      = 1'b0;
        wb         = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pending_wb = '0;
        exp_ex     = '0;
        mismatches = 0;
        failures   = 0;
        checks     = 0;
        seed       = 32'h85bb1f30;

        fd = $fopen(vec_file, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", vec_file);
            failures++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    if (line[0] == "I" || line[0] == "W" || line[0] == "A") begin
                        lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
        n_lines = lines.size();
        if (n_lines == 0) begin
            $display("vector file holds no stimulus lines");
            failures++;
            n_lines = 1;
        end
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ex(exp_ex, ex);
        check_word("pready", 1'b0, pready);
        check_word("pslverr", 1'b0, pslverr);

        foreach (lines[i]) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(posedge clk);
            case (lines[i][0])
                "I":     run_inst(lines[i]);
                "W":     load_wb(lines[i]);
                default: run_apb(lines[i]);
            endcase
        end
        repeat (2) @(posedge clk);

        $display("checks %0d, mismatches %0d, other failures %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src/id_stage.sv
module id_stage #(
    parameter int apb_addr_width = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [rv_id_pkg::xlen-1:0] inst,
    input  logic [29:0]                pc,
    input  logic                       stall,
    input  logic                       flush,
    input  rv_id_pkg::wb_t             wb,
    output rv_id_pkg::fwd_t            fwd,
    output rv_id_pkg::id_ex_t          ex,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [apb_addr_width-1:0]  paddr,
    input  logic [rv_id_pkg::xlen-1:0] pwdata,
    output logic [rv_id_pkg::xlen-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);

    rv_id_pkg::decoded_t        dec;
    rv_id_pkg::wb_t             rf_wr;
    logic [rv_id_pkg::xlen-1:0] rs1_data;
    logic [rv_id_pkg::xlen-1:0] rs2_data;
    logic [rv_id_pkg::xlen-1:0] mon_data;
    logic [4:0]                 mon_addr;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec),
        .fwd  (fwd)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (fwd.rs1),
        .rs2_addr (fwd.rs2),
        .mon_addr (mon_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .mon_data (mon_data),
        .wr       (rf_wr)
    );

    // monitor access, merged with write-back
    rf_apb_port #(
        .addr_width (apb_addr_width)
    ) u_apb_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .wb       (wb),
        .mon_addr (mon_addr),
        .mon_data (mon_data),
        .rf_wr    (rf_wr)
    );

    id_ex_reg u_id_ex_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .pc       (pc),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex       (ex)
    );

endmodule

//--- src/id_ex_reg.sv
module id_ex_reg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       flush,
    input  logic [29:0]                pc,
    input  rv_id_pkg::decoded_t        dec,
    input  logic [rv_id_pkg::xlen-1:0] rs1_data,
    input  logic [rv_id_pkg::xlen-1:0] rs2_data,
    output rv_id_pkg::id_ex_t          ex
);

    logic                       valid_q;
    rv_id_pkg::decoded_t        dec_q;
    logic [29:0]                pc_q;
    logic [rv_id_pkg::xlen-1:0] rs1_q;
    logic [rv_id_pkg::xlen-1:0] rs2_q;

    // flush beats stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            dec_q   <= '0;
        end else if (flush) begin
            valid_q        <= 1'b0;
            dec_q.kind     <= rv_id_pkg::none;
            dec_q.rd_we    <= 1'b0;
            dec_q.illegal  <= 1'b0;
            dec_q.rs1_used <= 1'b0;
            dec_q.rs2_used <= 1'b0;
        end else if (!stall) begin
            valid_q <= 1'b1;
            dec_q   <= dec;
        end
    end

    // operand data and pc
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_q  <= pc;
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
        end
    end

    assign ex = '{valid:    valid_q,
                  pc:       pc_q,
                  dec:      dec_q,
                  rs1_data: rs1_q,
                  rs2_data: rs2_q};

    a_flush_kills_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !ex.valid && ex.dec.kind == rv_id_pkg::none
    ) else $error("id_ex_reg: ex still valid after flush");

endmodule

//--- src/rf_apb_port.sv
module rf_apb_port #(
    parameter int addr_width = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [addr_width-1:0]      paddr,
    input  logic [rv_id_pkg::xlen-1:0] pwdata,
    output logic [rv_id_pkg::xlen-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  rv_id_pkg::wb_t             wb,
    output logic [4:0]                 mon_addr,
    input  logic [rv_id_pkg::xlen-1:0] mon_data,
    output rv_id_pkg::wb_t             rf_wr
);

    logic [addr_width-3:0] word_addr;
    logic                  out_of_range;
    logic                  xfer_q;
    logic                  access;
    logic                  wr_ok;

    assign word_addr    = paddr[addr_width-1:2];
    assign out_of_range = (word_addr >= rv_id_pkg::nregs);
    assign mon_addr     = word_addr[4:0];

    // set by the setup phase, dropped once the access completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer_q <= 1'b0;
        end else if (psel && !penable) begin
            xfer_q <= 1'b1;
        end else if (pready) begin
            xfer_q <= 1'b0;
        end
    end

    assign access  = psel && penable && xfer_q;
    // writes wait out write-back
    assign pready  = access && (!pwrite || out_of_range || !wb.we);
    assign pslverr = access && out_of_range;
    assign prdata  = (access && !pwrite && !out_of_range) ? mon_data : '0;
    assign wr_ok   = access && pwrite && !out_of_range && !wb.we;

    always_comb begin
        rf_wr = wb;
        if (wr_ok) begin
            rf_wr = '{we: 1'b1, addr: mon_addr, data: pwdata};
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    ) else $error("rf_apb_port: penable high without psel");

endmodule

//--- src/reg_file.sv
module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [4:0]                 rs1_addr,
    input  logic [4:0]                 rs2_addr,
    input  logic [4:0]                 mon_addr,
    output logic [rv_id_pkg::xlen-1:0] rs1_data,
    output logic [rv_id_pkg::xlen-1:0] rs2_data,
    output logic [rv_id_pkg::xlen-1:0] mon_data,
    input  rv_id_pkg::wb_t             wr
);

    // x0 has no storage
    logic [rv_id_pkg::xlen-1:0] regs [1:rv_id_pkg::nregs-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < rv_id_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    assign mon_data = (mon_addr == 5'd0) ? '0 : regs[mon_addr];

    // x0 stays zero on every port after a write aimed at it
    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr.we && wr.addr == 5'd0)
        |=> ((rs1_addr != 5'd0 || rs1_data == '0)
             && (rs2_addr != 5'd0 || rs2_data == '0)
             && (mon_addr != 5'd0 || mon_data == '0))
    ) else $error("reg_file: x0 read back non-zero");

endmodule

//--- src/inst_decoder.sv
module inst_decoder (
    input  rv_id_pkg::inst_u    inst,
    output rv_id_pkg::decoded_t dec,
    output rv_id_pkg::fwd_t     fwd
);

    rv_id_pkg::op_kind_e kind;
    logic                matched;
    logic [31:0]         imm;
    logic [31:0]         imm_i;
    logic [31:0]         imm_s;
    logic [31:0]         imm_b;
    logic [31:0]         imm_u;
    logic [31:0]         imm_j;
    logic                zero_26_25;
    logic                fence_zero;
    logic                sys_zero;
    logic                rd_we;
    logic                rs1_used;
    logic                rs2_used;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'd0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    // fields that must be zero
    assign zero_26_25 = (inst.r.funct7[1:0] == 2'b00);
    assign fence_zero = (inst.i.imm[11:8] == 4'd0) && (inst.r.rs1 == 5'd0)
                        && (inst.r.rd == 5'd0);
    assign sys_zero   = zero_26_25 && (inst.r.rs1 == 5'd0) && (inst.r.rd == 5'd0);

    always_comb begin
        kind    = rv_id_pkg::none;
        matched = 1'b1;
        case (inst.r.opcode)
            rv_id_pkg::op_lui:    kind = rv_id_pkg::lui;
            rv_id_pkg::op_auipc:  kind = rv_id_pkg::auipc;
            rv_id_pkg::op_jal:    kind = rv_id_pkg::jal;
            rv_id_pkg::op_jalr:   kind = rv_id_pkg::jalr;
            rv_id_pkg::op_branch: kind = rv_id_pkg::branch;
            rv_id_pkg::op_load:   kind = rv_id_pkg::load;
            rv_id_pkg::op_store:  kind = rv_id_pkg::store;
            rv_id_pkg::op_alui: begin
                if (inst.r.funct3 == 3'b001 || inst.r.funct3 == 3'b101) begin
                    // shifts only need bit 26 clear
                    kind    = rv_id_pkg::alui_shamt;
                    matched = !inst.r.funct7[1];
                end else begin
                    kind = rv_id_pkg::alui;
                end
            end
            rv_id_pkg::op_alu: begin
                kind    = rv_id_pkg::alu;
                matched = zero_26_25;
            end
            rv_id_pkg::op_fence: begin
                if (inst.r.funct3 == 3'b000) begin
                    kind    = rv_id_pkg::fence;
                    matched = fence_zero;
                end else begin
                    kind    = rv_id_pkg::fencei;
                    matched = fence_zero && (inst.r.funct3 == 3'b001)
                              && (inst.i.imm[7:0] == 8'd0);
                end
            end
            rv_id_pkg::op_system: begin
                if (inst.r.funct3 != 3'b000) begin
                    kind = rv_id_pkg::csr;
                end else begin
                    // funct7[6:2] and rs2 pick the privileged op
                    case ({inst.r.funct7[6:2], inst.r.rs2})
                        10'b00000_00000: kind = rv_id_pkg::ecall;
                        10'b00000_00001: kind = rv_id_pkg::ebreak;
                        10'b00110_00010: kind = rv_id_pkg::mret;
                        10'b00010_00101: kind = rv_id_pkg::wfi;
                        default:         matched = 1'b0;
                    endcase
                    matched = matched && sys_zero;
                end
            end
            default: matched = 1'b0;
        endcase
        // jalr, branch and load/store widths
        if (kind == rv_id_pkg::jalr && inst.r.funct3 != 3'b000) matched = 1'b0;
        if (kind == rv_id_pkg::branch && inst.r.funct3[2:1] == 2'b01) matched = 1'b0;
        if (kind == rv_id_pkg::load && (inst.r.funct3 == 3'b011 || inst.r.funct3[2:1] == 2'b11))
            matched = 1'b0;
        if (kind == rv_id_pkg::store && inst.r.funct3[2]) matched = 1'b0;
        if (inst.r.quad != 2'b11) matched = 1'b0;
        if (!matched) kind = rv_id_pkg::none;
    end

    always_comb begin
        case (kind)
            rv_id_pkg::lui, rv_id_pkg::auipc:                  imm = imm_u;
            rv_id_pkg::load, rv_id_pkg::jalr, rv_id_pkg::alui: imm = imm_i;
            rv_id_pkg::store:                                  imm = imm_s;
            rv_id_pkg::branch:                                 imm = imm_b;
            rv_id_pkg::jal:                                    imm = imm_j;
            rv_id_pkg::alui_shamt:                             imm = {27'd0, inst.r.rs2};
            // csr address, unsigned
            rv_id_pkg::csr:                                    imm = {20'd0, inst.i.imm};
            default:                                           imm = '0;
        endcase
    end

    assign rd_we = kind inside {rv_id_pkg::lui, rv_id_pkg::auipc, rv_id_pkg::load,
                                rv_id_pkg::jal, rv_id_pkg::jalr, rv_id_pkg::alu,
                                rv_id_pkg::alui, rv_id_pkg::alui_shamt, rv_id_pkg::csr};
    assign rs1_used = kind inside {rv_id_pkg::load, rv_id_pkg::store, rv_id_pkg::jalr,
                                   rv_id_pkg::branch, rv_id_pkg::alu, rv_id_pkg::alui,
                                   rv_id_pkg::alui_shamt, rv_id_pkg::csr};
    assign rs2_used = kind inside {rv_id_pkg::store, rv_id_pkg::branch, rv_id_pkg::alu};

    assign dec = '{kind:     kind,
                   funct3:   matched ? inst.r.funct3 : 3'd0,
                   alt:      (kind == rv_id_pkg::alu || kind == rv_id_pkg::alui_shamt)
                             && inst.r.funct7[5],
                   imm:      imm,
                   rd:       rd_we ? inst.r.rd : 5'd0,
                   rd_we:    rd_we,
                   illegal:  !matched,
                   rs1_used: rs1_used,
                   rs2_used: rs2_used};

    assign fwd = '{rs1: inst.r.rs1, rs2: inst.r.rs2, rs1_used: rs1_used, rs2_used: rs2_used};

    // an illegal word must carry no kind and no register traffic
    always_comb begin
        assert final ((dec.illegal == (dec.kind == rv_id_pkg::none))
                      && !(dec.illegal && (dec.rd_we || fwd.rs1_used || fwd.rs2_used)))
        else $error("decoder: illegal flag disagrees with kind");
    end

endmodule

//--- src/rv_id_pkg.sv
package rv_id_pkg;

    localparam int xlen  = 32;
    localparam int nregs = 32;

    // major opcodes, inst[6:2]
    localparam logic [4:0] op_lui    = 5'b01101;
    localparam logic [4:0] op_auipc  = 5'b00101;
    localparam logic [4:0] op_jal    = 5'b11011;
    localparam logic [4:0] op_jalr   = 5'b11001;
    localparam logic [4:0] op_branch = 5'b11000;
    localparam logic [4:0] op_load   = 5'b00000;
    localparam logic [4:0] op_store  = 5'b01000;
    localparam logic [4:0] op_alui   = 5'b00100;
    localparam logic [4:0] op_alu    = 5'b01100;
    localparam logic [4:0] op_fence  = 5'b00011;
    localparam logic [4:0] op_system = 5'b11100;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] opcode;
        logic [1:0] quad;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  op;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] op;
    } inst_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] op;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  op;
    } inst_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] op;
    } inst_j_t;

    // one instruction word, six views
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

    typedef enum logic [4:0] {
        none, lui, auipc, load, store, jal, jalr, branch, alu, alui,
        alui_shamt, fence, fencei, csr, ecall, ebreak, mret, wfi
    } op_kind_e;

    typedef struct packed {
        op_kind_e          kind;
        logic [2:0]        funct3;
        logic              alt;
        logic [xlen-1:0]   imm;
        logic [4:0]        rd;
        logic              rd_we;
        logic              illegal;
        logic              rs1_used;
        logic              rs2_used;
    } decoded_t;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       rs1_used;
        logic       rs2_used;
    } fwd_t;

    typedef struct packed {
        logic            valid;
        logic [29:0]     pc;
        decoded_t        dec;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
    } id_ex_t;

    typedef struct packed {
        logic            we;
        logic [4:0]      addr;
        logic [xlen-1:0] data;
    } wb_t;

endpackage
